// File: mam_subsys.f
+incdir+.
mam_pkg.sv
mam_fifo.sv
mam_dbg_master.sv
mam_adapter_ahb3.sv
mam_ahb3_ram.sv
mam_subsys_top.sv
mam_subsys_sva.sv
tb_mam_subsys.sv

// File: Bender.yml
package:
  name: mam_subsys

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - mam_pkg.sv
      - mam_fifo.sv
      - mam_dbg_master.sv
      - mam_adapter_ahb3.sv
      - mam_ahb3_ram.sv
      - mam_subsys_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - mam_subsys_sva.sv
      - tb_mam_subsys.sv

// File: tb_mam_subsys.sv
`timescale 1ns/1ps
`default_nettype none

`include "mam_consts.svh"

module tb_mam_subsys import mam_pkg::*; ();

  localparam int CLK_NS       = 20;
  localparam int RESET_CYCLES = 5;
  localparam int NUM_TESTS    = 6;
  localparam int TEST_CYCLES  = 400;
  localparam int WATCHDOG_NS  = (NUM_TESTS * TEST_CYCLES + RESET_CYCLES) * CLK_NS;
  localparam int WORDS        = `MAM_RAM_WORDS;
  localparam int BP_CMDS      = `MAM_FIFO_DEPTH * 2 + 2;

  logic      ahb3_in_clk;
  logic      rst_n;
  ahb3_req_t cpu_req;
  ahb3_rsp_t cpu_rsp;
  logic      dbg_cmd_push;
  mam_cmd_t  dbg_cmd;
  logic      dbg_cmd_full;
  logic      dbg_rsp_pop;
  logic      dbg_rsp_empty;
  mam_rsp_t  dbg_rsp;

  // Reference memory and the word addresses written so far
  logic [`MAM_XLEN-1:0] ref_mem [int unsigned];
  int unsigned          used_q [$];
  int                   err_cnt = 0;
  int                   chk_cnt = 0;
  int                   sva_cnt;

  mam_subsys_top i_mam_subsys_top (
    .ahb3_in_clk_i   (ahb3_in_clk),
    .rst_n_i         (rst_n),
    .cpu_req_i       (cpu_req),
    .cpu_rsp_o       (cpu_rsp),
    .dbg_cmd_push_i  (dbg_cmd_push),
    .dbg_cmd_i       (dbg_cmd),
    .dbg_cmd_full_o  (dbg_cmd_full),
    .dbg_rsp_pop_i   (dbg_rsp_pop),
    .dbg_rsp_empty_o (dbg_rsp_empty),
    .dbg_rsp_o       (dbg_rsp)
  );

  initial begin
    ahb3_in_clk = 1'b0;
    forever #(CLK_NS / 2) ahb3_in_clk = ~ahb3_in_clk;
  end

  // Whole run bounded by the number of tests
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Simulation failed");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Checking and reference model
  //////////////////////////////////////////////////////////////////////

  task automatic compare(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
    chk_cnt++;
    if (actual !== expected) begin
      err_cnt++;
      $display("Error at %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
    end
  endtask

  function automatic logic in_range(input int unsigned word);
    return word < WORDS;
  endfunction

  // Out of range reads give zero data
  function automatic logic [`MAM_XLEN-1:0] exp_word(input int unsigned word);
    return in_range(word) ? ref_mem[word] : '0;
  endfunction

  // Expected debug response, writes update the model
  function automatic mam_rsp_t apply_cmd(input mam_cmd_t cmd);
    mam_rsp_t rsp;
    rsp = '0;
    if (!in_range(cmd.addr)) begin
      rsp.error = 1'b1;
    end else if (cmd.write) begin
      ref_mem[cmd.addr] = cmd.wdata;
    end else begin
      rsp.rdata = ref_mem[cmd.addr];
    end
    return rsp;
  endfunction

  function automatic mam_cmd_t make_cmd(input logic write, input int unsigned word,
                                        input logic [`MAM_XLEN-1:0] wdata);
    mam_cmd_t cmd;
    cmd.write = write;
    cmd.addr  = word;
    cmd.wdata = wdata;
    return cmd;
  endfunction

  function automatic int unsigned new_word();
    int unsigned word;
    word = $urandom_range(WORDS - 1, 0);
    used_q.push_back(word);
    return word;
  endfunction

  function automatic int unsigned pick_used();
    return used_q[$urandom_range(used_q.size() - 1, 0)];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // CPU bus
  //////////////////////////////////////////////////////////////////////

  task automatic cpu_xfer(input logic write, input int unsigned word,
                          input logic [`MAM_XLEN-1:0] wdata,
                          output logic [`MAM_XLEN-1:0] rdata, output logic resp);
    // Lock first, address phase held back
    @(posedge ahb3_in_clk);
    cpu_req.hsel      <= 1'b1;
    cpu_req.hmastlock <= 1'b1;
    cpu_req.hwrite    <= write;
    cpu_req.haddr     <= {word[`MAM_PLEN-3:0], 2'b00};
    cpu_req.hwdata    <= wdata;
    cpu_req.hsize     <= HSIZE_WORD;
    cpu_req.hburst    <= HBURST_SINGLE;
    cpu_req.hprot     <= 4'b0011;
    cpu_req.htrans    <= HTRANS_IDLE;
    // Arbiter moves its state, then its select
    repeat (2) @(posedge ahb3_in_clk);
    cpu_req.htrans <= HTRANS_NONSEQ;
    // Address taken on an edge with hready high
    do @(negedge ahb3_in_clk); while (!cpu_rsp.hready);
    @(posedge ahb3_in_clk);
    cpu_req.htrans <= HTRANS_IDLE;
    // Data phase ends on the next hready
    do @(negedge ahb3_in_clk); while (!cpu_rsp.hready);
    rdata = cpu_rsp.hrdata;
    resp  = cpu_rsp.hresp;
    @(posedge ahb3_in_clk);
    cpu_req.hmastlock <= 1'b0;
    cpu_req.hsel      <= 1'b0;
  endtask

  task automatic cpu_write(input int unsigned word, input logic [`MAM_XLEN-1:0] data,
                           output logic resp);
    logic [`MAM_XLEN-1:0] unused;
    cpu_xfer(1'b1, word, data, unused, resp);
  endtask

  task automatic cpu_read(input int unsigned word, output logic [`MAM_XLEN-1:0] data,
                          output logic resp);
    cpu_xfer(1'b0, word, '0, data, resp);
  endtask

  task automatic write_via_cpu(input int unsigned word, input logic [`MAM_XLEN-1:0] data);
    logic resp;
    cpu_write(word, data, resp);
    compare("cpu_rsp_o.hresp", resp, !in_range(word));
    if (in_range(word)) begin
      ref_mem[word] = data;
    end
  endtask

  task automatic read_via_cpu(input int unsigned word);
    logic [`MAM_XLEN-1:0] data;
    logic                 resp;
    cpu_read(word, data, resp);
    compare("cpu_rsp_o.hresp", resp, !in_range(word));
    compare("cpu_rsp_o.hrdata", data, exp_word(word));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Debug host
  //////////////////////////////////////////////////////////////////////

  task automatic dbg_push(input mam_cmd_t cmd);
    do @(negedge ahb3_in_clk); while (dbg_cmd_full);
    @(posedge ahb3_in_clk);
    dbg_cmd_push <= 1'b1;
    dbg_cmd      <= cmd;
    @(posedge ahb3_in_clk);
    dbg_cmd_push <= 1'b0;
  endtask

  task automatic dbg_pop(output mam_rsp_t rsp);
    do @(negedge ahb3_in_clk); while (dbg_rsp_empty);
    // Head word is stable between edges
    rsp = dbg_rsp;
    @(posedge ahb3_in_clk);
    dbg_rsp_pop <= 1'b1;
    @(posedge ahb3_in_clk);
    dbg_rsp_pop <= 1'b0;
  endtask

  task automatic check_rsp(input mam_rsp_t got, input mam_rsp_t exp);
    compare("dbg_rsp_o.rdata", got.rdata, exp.rdata);
    compare("dbg_rsp_o.error", got.error, exp.error);
  endtask

  task automatic access_via_dbg(input mam_cmd_t cmd);
    mam_rsp_t exp;
    mam_rsp_t got;
    exp = apply_cmd(cmd);
    dbg_push(cmd);
    dbg_pop(got);
    check_rsp(got, exp);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    @(negedge ahb3_in_clk);
    compare("dbg_rsp_empty_o", dbg_rsp_empty, 1'b1);
    compare("dbg_cmd_full_o", dbg_cmd_full, 1'b0);
    compare("cpu_rsp_o.hready", cpu_rsp.hready, 1'b0);
  endtask

  task automatic test_cpu_random();
    int unsigned word;
    int          first;
    first = used_q.size();
    repeat (8) begin
      word = new_word();
      write_via_cpu(word, $urandom());
    end
    for (int i = first; i < used_q.size(); i++) begin
      read_via_cpu(used_q[i]);
    end
  endtask

  task automatic test_cross_path();
    int unsigned word;
    // Debug writes, CPU reads
    repeat (6) begin
      word = new_word();
      access_via_dbg(make_cmd(1'b1, word, $urandom()));
      read_via_cpu(word);
    end
    // CPU writes, debug reads
    repeat (6) begin
      word = new_word();
      write_via_cpu(word, $urandom());
      access_via_dbg(make_cmd(1'b0, word, '0));
    end
  endtask

  task automatic test_contention();
    int unsigned          word_a;
    int unsigned          word_b;
    logic [`MAM_XLEN-1:0] cpu_data;
    mam_cmd_t             cmd_a;
    mam_cmd_t             cmd_b;
    mam_rsp_t             exp_a;
    mam_rsp_t             exp_b;
    mam_rsp_t             got;
    word_a = new_word();
    word_b = new_word();
    // MAM owns the bus first so the CPU write lands last
    cmd_a = make_cmd(1'b1, word_a, $urandom());
    exp_a = apply_cmd(cmd_a);
    dbg_push(cmd_a);
    repeat (2) @(posedge ahb3_in_clk);
    write_via_cpu(word_a, $urandom());
    dbg_pop(got);
    check_rsp(got, exp_a);
    // Locked CPU finishes before the debug write
    cpu_data = $urandom();
    cmd_b    = make_cmd(1'b1, word_b, $urandom());
    fork
      write_via_cpu(word_b, cpu_data);
      begin
        repeat (4) @(posedge ahb3_in_clk);
        dbg_push(cmd_b);
      end
    join
    exp_b = apply_cmd(cmd_b);
    dbg_pop(got);
    check_rsp(got, exp_b);
    // Final contents from both sides
    read_via_cpu(word_a);
    read_via_cpu(word_b);
    access_via_dbg(make_cmd(1'b0, word_a, '0));
    access_via_dbg(make_cmd(1'b0, word_b, '0));
  endtask

  task automatic test_out_of_range();
    int unsigned base;
    // CPU side, the word at the wrapped index must survive
    base = pick_used();
    write_via_cpu(WORDS + base, $urandom());
    read_via_cpu(WORDS + base);
    read_via_cpu(base);
    // Debug side
    base = pick_used();
    access_via_dbg(make_cmd(1'b1, WORDS * 3 + base, $urandom()));
    access_via_dbg(make_cmd(1'b0, WORDS + base, '0));
    access_via_dbg(make_cmd(1'b0, base, '0));
    read_via_cpu(base);
  endtask

  task automatic test_back_pressure();
    mam_cmd_t cmds [BP_CMDS];
    mam_rsp_t exp [BP_CMDS];
    mam_rsp_t got;
    logic     seen_full;
    // Expected responses in command order
    for (int i = 0; i < BP_CMDS; i++) begin
      if ($urandom_range(1, 0) == 1) begin
        cmds[i] = make_cmd(1'b1, new_word(), $urandom());
      end else begin
        cmds[i] = make_cmd(1'b0, pick_used(), '0);
      end
      exp[i] = apply_cmd(cmds[i]);
    end
    for (int i = 0; i < BP_CMDS - 2; i++) begin
      dbg_push(cmds[i]);
    end
    // Both queues fill once the master stalls on a full response queue
    seen_full = 1'b0;
    for (int n = 0; n < 100 && !seen_full; n++) begin
      @(negedge ahb3_in_clk);
      seen_full = dbg_cmd_full;
    end
    compare("dbg_cmd_full_o", seen_full, 1'b1);
    fork
      for (int i = BP_CMDS - 2; i < BP_CMDS; i++) begin
        dbg_push(cmds[i]);
      end
      for (int j = 0; j < BP_CMDS; j++) begin
        dbg_pop(got);
        check_rsp(got, exp[j]);
      end
    join
    @(negedge ahb3_in_clk);
    compare("dbg_rsp_empty_o", dbg_rsp_empty, 1'b1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'hdd0));
    rst_n        = 1'b0;
    cpu_req      = '0;
    dbg_cmd_push = 1'b0;
    dbg_cmd      = '0;
    dbg_rsp_pop  = 1'b0;
    repeat (RESET_CYCLES) @(posedge ahb3_in_clk);
    rst_n <= 1'b1;

    test_reset();
    test_cpu_random();
    test_cross_path();
    test_contention();
    test_out_of_range();
    test_back_pressure();

    sva_cnt = i_mam_subsys_top.i_adapter.i_adapter_sva.fail_cnt;
    $display("Checks: %0d, check errors: %0d, assertion failures: %0d",
             chk_cnt, err_cnt, sva_cnt);
    if (err_cnt == 0 && sva_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: mam_subsys_sva.sv
`timescale 1ns/1ps
`default_nettype none

module mam_subsys_sva import mam_pkg::*; (
  input wire logic       ahb3_in_clk_i,
  input wire logic       rst_n_i,
  input wire arb_state_t arb_state,
  input wire logic       mam_lock,
  input wire logic [1:0] mam_htrans,
  input wire logic       mam_hready
);

  // Failed assertions, read by the testbench at the end of the run
  int unsigned fail_cnt = 0;

  // Only the three defined encodings
  a_state_valid : assert property (@(posedge ahb3_in_clk_i) disable iff (!rst_n_i)
    arb_state inside {IDLE, ACCESS_MAM, ACCESS_CPU})
  else begin
    fail_cnt++;
    $error("arbiter state %0d is not a valid encoding", arb_state);
  end

  // MAM lock seen in IDLE wins on the next edge
  a_mam_priority : assert property (@(posedge ahb3_in_clk_i) disable iff (!rst_n_i)
    (arb_state == IDLE) && mam_lock |=> (arb_state == ACCESS_MAM))
  else begin
    fail_cnt++;
    $error("arbiter did not move from IDLE to ACCESS_MAM after a MAM lock");
  end

  // MAM address phase must wait while the CPU owns the RAM
  a_mam_blocked : assert property (@(posedge ahb3_in_clk_i) disable iff (!rst_n_i)
    (arb_state == ACCESS_CPU) && (mam_htrans == HTRANS_NONSEQ) |-> !mam_hready)
  else begin
    fail_cnt++;
    $error("MAM sees hready high while the CPU is selected");
  end

endmodule

bind mam_adapter_ahb3 mam_subsys_sva i_adapter_sva (
  .ahb3_in_clk_i (ahb3_in_clk_i),
  .rst_n_i       (rst_n_i),
  .arb_state     (arb_state),
  .mam_lock      (mam_req_i.hmastlock),
  .mam_htrans    (mam_req_i.htrans),
  .mam_hready    (mam_rsp_o.hready)
);

`default_nettype wire

// File: mam_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mam_consts.svh"

module mam_subsys_top import mam_pkg::*; (
  input  wire logic      ahb3_in_clk_i,
  input  wire logic      rst_n_i,
  // CPU bus
  input  wire ahb3_req_t cpu_req_i,
  output ahb3_rsp_t      cpu_rsp_o,
  // Debug host command queue
  input  wire logic      dbg_cmd_push_i,
  input  wire mam_cmd_t  dbg_cmd_i,
  output logic           dbg_cmd_full_o,
  // Debug host response queue
  input  wire logic      dbg_rsp_pop_i,
  output logic           dbg_rsp_empty_o,
  output mam_rsp_t       dbg_rsp_o
);

  mam_cmd_t  cmd_head;
  logic      cmd_empty;
  logic      cmd_pop;
  mam_rsp_t  rsp_data;
  logic      rsp_push;
  logic      rsp_full;
  ahb3_req_t mam_req;
  ahb3_rsp_t mam_rsp;
  ahb3_req_t mem_req;
  ahb3_rsp_t mem_rsp;

  //////////////////////////////////////////////////////////////////////
  // Host queues
  //////////////////////////////////////////////////////////////////////

  mam_fifo #(
    .payload_t (mam_cmd_t),
    .DEPTH     (`MAM_FIFO_DEPTH)
  ) i_cmd_fifo (
    .ahb3_in_clk_i (ahb3_in_clk_i),
    .rst_n_i       (rst_n_i),
    .push_i        (dbg_cmd_push_i),
    .data_i        (dbg_cmd_i),
    .pop_i         (cmd_pop),
    .data_o        (cmd_head),
    .empty_o       (cmd_empty),
    .full_o        (dbg_cmd_full_o)
  );

  mam_fifo #(
    .payload_t (mam_rsp_t),
    .DEPTH     (`MAM_FIFO_DEPTH)
  ) i_rsp_fifo (
    .ahb3_in_clk_i (ahb3_in_clk_i),
    .rst_n_i       (rst_n_i),
    .push_i        (rsp_push),
    .data_i        (rsp_data),
    .pop_i         (dbg_rsp_pop_i),
    .data_o        (dbg_rsp_o),
    .empty_o       (dbg_rsp_empty_o),
    .full_o        (rsp_full)
  );

  //////////////////////////////////////////////////////////////////////
  // Bus path
  //////////////////////////////////////////////////////////////////////

  mam_dbg_master i_dbg_master (
    .ahb3_in_clk_i (ahb3_in_clk_i),
    .rst_n_i       (rst_n_i),
    .cmd_i         (cmd_head),
    .cmd_empty_i   (cmd_empty),
    .cmd_pop_o     (cmd_pop),
    .rsp_full_i    (rsp_full),
    .rsp_push_o    (rsp_push),
    .rsp_o         (rsp_data),
    .mam_req_o     (mam_req),
    .mam_rsp_i     (mam_rsp)
  );

  mam_adapter_ahb3 i_adapter (
    .ahb3_in_clk_i (ahb3_in_clk_i),
    .rst_n_i       (rst_n_i),
    .cpu_req_i     (cpu_req_i),
    .cpu_rsp_o     (cpu_rsp_o),
    .mam_req_i     (mam_req),
    .mam_rsp_o     (mam_rsp),
    .mem_req_o     (mem_req),
    .mem_rsp_i     (mem_rsp)
  );

  mam_ahb3_ram i_ram (
    .ahb3_in_clk_i (ahb3_in_clk_i),
    .rst_n_i       (rst_n_i),
    .req_i         (mem_req),
    .rsp_o         (mem_rsp)
  );

endmodule

`default_nettype wire

// File: mam_ahb3_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "mam_consts.svh"

module mam_ahb3_ram import mam_pkg::*; (
  input  wire logic      ahb3_in_clk_i,
  input  wire logic      rst_n_i,
  input  wire ahb3_req_t req_i,
  output ahb3_rsp_t      rsp_o
);

  localparam int WAIT = `MAM_RAM_WAIT;
  // Counter width, one bit minimum for zero wait states
  localparam int CW   = (WAIT > 0) ? $clog2(WAIT + 1) : 1;
  localparam int AW   = $clog2(`MAM_RAM_WORDS);
  // Word address, byte lanes dropped
  localparam int WW   = `MAM_PLEN - 2;

  logic [`MAM_XLEN-1:0] mem [`MAM_RAM_WORDS];

  logic          busy_q;
  logic [CW-1:0] wait_cnt_q;
  logic [WW-1:0] addr_q;
  logic          write_q;
  logic          accept;
  logic          done;
  logic          in_range;

  // Address phase needs select, NONSEQ and our own hready
  assign accept   = req_i.hsel && (req_i.htrans == HTRANS_NONSEQ) && rsp_o.hready;
  // Last cycle of the data phase
  assign done     = busy_q && (wait_cnt_q == '0);
  assign in_range = (addr_q < WW'(`MAM_RAM_WORDS));

  //////////////////////////////////////////////////////////////////////
  // Data phase control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge ahb3_in_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q     <= 1'b0;
      wait_cnt_q <= '0;
    end else if (accept) begin
      // Back to back is fine, a new address may land on the done edge
      busy_q     <= 1'b1;
      wait_cnt_q <= CW'(WAIT);
    end else if (done) begin
      busy_q     <= 1'b0;
    end else if (busy_q) begin
      wait_cnt_q <= wait_cnt_q - 1'b1;
    end
  end

  // Captured address phase
  always_ff @(posedge ahb3_in_clk_i) begin
    if (accept) begin
      addr_q  <= req_i.haddr[`MAM_PLEN-1:2];
      write_q <= req_i.hwrite;
    end
  end

  // hwdata is valid in the data phase, out of range leaves memory alone
  always_ff @(posedge ahb3_in_clk_i) begin
    if (done && write_q && in_range) begin
      mem[addr_q[AW-1:0]] <= req_i.hwdata;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Response
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // Ready when idle and on the last data cycle
    rsp_o.hready = !busy_q || (wait_cnt_q == '0);
    rsp_o.hresp  = done && !in_range;
    rsp_o.hrdata = (done && !write_q && in_range) ? mem[addr_q[AW-1:0]] : '0;
  end

endmodule

`default_nettype wire

// File: mam_adapter_ahb3.sv
`timescale 1ns/1ps
`default_nettype none

module mam_adapter_ahb3 import mam_pkg::*; (
  input  wire logic      ahb3_in_clk_i,
  input  wire logic      rst_n_i,
  // CPU side
  input  wire ahb3_req_t cpu_req_i,
  output ahb3_rsp_t      cpu_rsp_o,
  // Debug MAM side
  input  wire ahb3_req_t mam_req_i,
  output ahb3_rsp_t      mam_rsp_o,
  // Shared RAM port
  output ahb3_req_t      mem_req_o,
  input  wire ahb3_rsp_t mem_rsp_i
);

  //////////////////////////////////////////////////////////////////////
  // Arbiter
  //////////////////////////////////////////////////////////////////////

  arb_state_t arb_state;
  arb_state_t arb_state_next;
  logic       grant_cpu;
  logic       grant_mam;
  // Registered select, high routes the RAM to the CPU
  logic       access_cpu;

  always_ff @(posedge ahb3_in_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      arb_state  <= IDLE;
      access_cpu <= 1'b0;
    end else begin
      arb_state <= arb_state_next;
      // Select lags the state by one edge
      // IDLE keeps the last select
      if (grant_cpu) begin
        access_cpu <= 1'b1;
      end else if (grant_mam) begin
        access_cpu <= 1'b0;
      end
    end
  end

  always_comb begin
    grant_cpu      = 1'b0;
    grant_mam      = 1'b0;
    arb_state_next = IDLE;

    case (arb_state)
      // MAM wins a tie from idle
      IDLE: begin
        if (mam_req_i.hmastlock) begin
          arb_state_next = ACCESS_MAM;
        end else if (cpu_req_i.hmastlock) begin
          arb_state_next = ACCESS_CPU;
        end
      end

      // Held until the MAM drops its lock
      ACCESS_MAM: begin
        grant_mam = 1'b1;
        if (mam_req_i.hmastlock) begin
          arb_state_next = ACCESS_MAM;
        end
      end

      // Locked CPU finishes first, then a waiting MAM goes straight in
      ACCESS_CPU: begin
        grant_cpu = 1'b1;
        if (cpu_req_i.hmastlock) begin
          arb_state_next = ACCESS_CPU;
        end else if (mam_req_i.hmastlock) begin
          arb_state_next = ACCESS_MAM;
        end
      end

      // Unused encoding falls back to idle
      default: arb_state_next = IDLE;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Data path
  //////////////////////////////////////////////////////////////////////

  // Whole request bundle to memory
  assign mem_req_o = access_cpu ? cpu_req_i : mam_req_i;

  // Unselected side sees zero hready and waits
  assign cpu_rsp_o = access_cpu ? mem_rsp_i : '0;
  assign mam_rsp_o = access_cpu ? '0 : mem_rsp_i;

endmodule

`default_nettype wire

// File: mam_dbg_master.sv
`timescale 1ns/1ps
`default_nettype none

`include "mam_consts.svh"

module mam_dbg_master import mam_pkg::*; (
  input  wire logic      ahb3_in_clk_i,
  input  wire logic      rst_n_i,
  // Command queue head
  input  wire mam_cmd_t  cmd_i,
  input  wire logic      cmd_empty_i,
  output logic           cmd_pop_o,
  // Response queue
  input  wire logic      rsp_full_i,
  output logic           rsp_push_o,
  output mam_rsp_t       rsp_o,
  // AHB3 master port toward the adapter
  output ahb3_req_t      mam_req_o,
  input  wire ahb3_rsp_t mam_rsp_i
);

  //////////////////////////////////////////////////////////////////////
  // Command sequencing
  //////////////////////////////////////////////////////////////////////

  // Idle, request lock, address phase, data phase
  typedef enum logic [1:0] {
    DBG_IDLE = 2'd0,
    DBG_LOCK = 2'd1,
    DBG_ADDR = 2'd2,
    DBG_DATA = 2'd3
  } dbg_state_t;

  dbg_state_t state;
  dbg_state_t state_next;
  mam_cmd_t   cmd_q;
  logic       start;
  logic       done;

  // Start only with room for the response
  assign start = (state == DBG_IDLE) && !cmd_empty_i && !rsp_full_i;
  // Data phase ends on the first edge with hready high
  assign done  = (state == DBG_DATA) && mam_rsp_i.hready;

  assign cmd_pop_o  = start;
  assign rsp_push_o = done;

  always_ff @(posedge ahb3_in_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state <= DBG_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Command held for the whole transfer
  always_ff @(posedge ahb3_in_clk_i) begin
    if (start) begin
      cmd_q <= cmd_i;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      DBG_IDLE: if (start) state_next = DBG_LOCK;
      // One cycle of lock alone lets the arbiter settle its select
      DBG_LOCK: state_next = DBG_ADDR;
      // Address accepted when our hready is high
      DBG_ADDR: if (mam_rsp_i.hready) state_next = DBG_DATA;
      DBG_DATA: if (done) state_next = DBG_IDLE;
      default:  state_next = DBG_IDLE;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Bus drive and response
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    mam_req_o           = '0;
    // Lock from the lock step until the data phase ends
    mam_req_o.hmastlock = (state != DBG_IDLE);
    mam_req_o.hsel      = (state != DBG_IDLE);
    // Word address to byte address
    mam_req_o.haddr     = {cmd_q.addr[`MAM_PLEN-3:0], 2'b00};
    mam_req_o.hwdata    = cmd_q.wdata;
    mam_req_o.hwrite    = cmd_q.write;
    mam_req_o.hsize     = HSIZE_WORD;
    mam_req_o.hburst    = HBURST_SINGLE;
    mam_req_o.htrans    = (state == DBG_ADDR) ? HTRANS_NONSEQ : HTRANS_IDLE;
  end

  // Sampled by the response queue on the done edge
  always_comb begin
    rsp_o.rdata = cmd_q.write ? '0 : mam_rsp_i.hrdata;
    rsp_o.error = mam_rsp_i.hresp;
  end

endmodule

`default_nettype wire

// File: mam_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "mam_consts.svh"

module mam_fifo #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = `MAM_FIFO_DEPTH
) (
  input  wire logic     ahb3_in_clk_i,
  input  wire logic     rst_n_i,
  input  wire logic     push_i,
  input  wire payload_t data_i,
  input  wire logic     pop_i,
  output payload_t      data_o,
  output logic          empty_o,
  output logic          full_o
);

  // Pointer and count widths, one bit minimum
  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [CW-1:0]    count;
  logic             push_ok;
  logic             pop_ok;

  // Push while full and pop while empty are dropped
  assign push_ok = push_i && !full_o;
  assign pop_ok  = pop_i && !empty_o;

  assign empty_o = (count == '0);
  assign full_o  = (count == CW'(DEPTH));

  // Head word straight from storage
  assign data_o = mem[rd_ptr];

  // Storage, no reset
  always_ff @(posedge ahb3_in_clk_i) begin
    if (push_ok) begin
      mem[wr_ptr] <= data_i;
    end
  end

  // Pointers wrap at DEPTH, depth need not be a power of two
  always_ff @(posedge ahb3_in_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Occupancy holds on simultaneous push and pop
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: mam_pkg.sv
`default_nettype none

package mam_pkg;

  `include "mam_consts.svh"

  //////////////////////////////////////////////////////////////////////
  // AHB3 encodings
  //////////////////////////////////////////////////////////////////////

  // Transfer types used here, no SEQ and no BUSY
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

  // Single word transfers only
  localparam logic [2:0] HSIZE_WORD    = 3'b010;
  localparam logic [2:0] HBURST_SINGLE = 3'b000;

  // Master to slave bundle
  typedef struct packed {
    logic                 hsel;
    logic [`MAM_PLEN-1:0] haddr;
    logic [`MAM_XLEN-1:0] hwdata;
    logic                 hwrite;
    logic [2:0]           hsize;
    logic [2:0]           hburst;
    logic [`MAM_SW-1:0]   hprot;
    logic [1:0]           htrans;
    logic                 hmastlock;
  } ahb3_req_t;

  // Slave to master bundle
  typedef struct packed {
    logic [`MAM_XLEN-1:0] hrdata;
    logic                 hready;
    logic                 hresp;
  } ahb3_rsp_t;

  //////////////////////////////////////////////////////////////////////
  // Debug host side
  //////////////////////////////////////////////////////////////////////

  // One command is one word access, addr counts words
  typedef struct packed {
    logic [`MAM_PLEN-1:0] addr;
    logic [`MAM_XLEN-1:0] wdata;
    logic                 write;
  } mam_cmd_t;

  // One response per command, write returns zero data
  typedef struct packed {
    logic [`MAM_XLEN-1:0] rdata;
    logic                 error;
  } mam_rsp_t;

  // Shared RAM arbiter states
  typedef enum logic [1:0] {
    IDLE       = 2'd0,
    ACCESS_MAM = 2'd1,
    ACCESS_CPU = 2'd2
  } arb_state_t;

endpackage

`default_nettype wire

// File: mam_consts.svh
`ifndef MAM_CONSTS_SVH
`define MAM_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// Bus widths
//////////////////////////////////////////////////////////////////////

// Byte address width on AHB3
`define MAM_PLEN 32
// Data width on AHB3
`define MAM_XLEN 32
// hprot width
`define MAM_SW 4

//////////////////////////////////////////////////////////////////////
// Memory and queues
//////////////////////////////////////////////////////////////////////

// Word count of the on-chip RAM, word addresses at or above are errors
`define MAM_RAM_WORDS 256
// Wait states inserted in every data phase
`define MAM_RAM_WAIT 2
// Default depth of the command and response queues
`define MAM_FIFO_DEPTH 4

`endif
